// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := tb_lat_mon
DUT_TOP    := lat_mon_top
FILELIST   := lat_mon_top.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
PASS_MSG   := Test OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: lat_mon_top.f
rtl/lat_mon_pkg.sv
rtl/lat_wb_pkg.sv
rtl/lat_event_capture.sv
rtl/lat_delta_stats.sv
rtl/lat_sample_arbiter.sv
rtl/lat_sample_ram.sv
rtl/lat_wb_regs.sv
rtl/lat_mon_top.sv
tb/lat_mon_properties.sv
tb/tb_lat_mon.sv

// File: rtl/lat_delta_stats.sv
`timescale 1ns/100ps
`default_nettype none

module lat_delta_stats (
    input  logic                i_clk,
    input  logic                i_rstn,
    input  lat_mon_pkg::ctrl_t  i_ctrl,
    input  lat_mon_pkg::delta_t i_delta,
    output lat_mon_pkg::stats_t o_stats
);

    lat_mon_pkg::timer_t lat_q;
    logic                lat_vld;

    // Latency stage, wraps modulo 2^16
    always_ff @(posedge i_clk) begin
        if (i_delta.valid) begin
            lat_q <= i_delta.rcvd - i_delta.sent
                   - lat_mon_pkg::TIMER_W'(lat_mon_pkg::DELTA_ADJ);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn || i_ctrl.clear) begin
            lat_vld <= 1'b0;
        end else begin
            lat_vld <= i_delta.valid;
        end
    end

    // Running statistics
    always_ff @(posedge i_clk) begin
        if (!i_rstn || i_ctrl.clear) begin
            o_stats.cnt     <= '0;
            o_stats.sum     <= '0;
            o_stats.lat_min <= '1;
            o_stats.lat_max <= '0;
        end else if (lat_vld) begin
            o_stats.cnt <= o_stats.cnt + 1'b1;
            o_stats.sum <= o_stats.sum + 32'(lat_q);
            if (lat_q < o_stats.lat_min) begin
                o_stats.lat_min <= lat_q;
            end
            if (lat_q > o_stats.lat_max) begin
                o_stats.lat_max <= lat_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lat_event_capture.sv
`timescale 1ns/100ps
`default_nettype none

module lat_event_capture (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    input  lat_mon_pkg::ctrl_t       i_ctrl,
    input  logic                     i_tx_sof,
    input  logic                     i_rx_sof,
    output lat_mon_pkg::rec_wr_t     o_sent_wr,
    output lat_mon_pkg::rec_wr_t     o_rcvd_wr,
    output lat_mon_pkg::delta_t      o_delta,
    output lat_mon_pkg::cap_status_t o_status
);

    lat_mon_pkg::timer_t timer;

    // Sent times waiting for their receive, oldest at q_rd
    lat_mon_pkg::timer_t sent_q [2**lat_mon_pkg::PEND_W];

    logic [lat_mon_pkg::PEND_W-1:0]    q_wr;
    logic [lat_mon_pkg::PEND_W-1:0]    q_rd;
    logic [lat_mon_pkg::PEND_W-1:0]    pending;
    logic [lat_mon_pkg::SAMPLE_AW-1:0] tx_idx;
    lat_mon_pkg::ptr_t                 rx_ptr;
    logic                              send_ev;
    logic                              rcv_ev;

    // ############################################################
    // Free-running timer
    // ############################################################
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // ############################################################
    // Event qualification
    // ############################################################
    assign send_ev = i_tx_sof & i_ctrl.go & !i_ctrl.clear
                   & (pending != lat_mon_pkg::PEND_W'(lat_mon_pkg::PENDING_MAX));

    // Only a receive with something in flight is paired
    assign rcv_ev = i_rx_sof & !i_ctrl.clear & (pending != '0);

    always_ff @(posedge i_clk) begin
        if (send_ev) begin
            sent_q[q_wr] <= timer;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn || i_ctrl.clear) begin
            q_wr            <= '0;
            q_rd            <= '0;
            pending         <= '0;
            tx_idx          <= '0;
            rx_ptr          <= '0;
            o_sent_wr.valid <= 1'b0;
            o_rcvd_wr.valid <= 1'b0;
            o_delta.valid   <= 1'b0;
        end else begin
            o_sent_wr.valid <= send_ev;
            o_rcvd_wr.valid <= rcv_ev;
            o_delta.valid   <= rcv_ev;

            if (send_ev) begin
                q_wr            <= q_wr + 1'b1;
                tx_idx          <= tx_idx + 1'b1;
                o_sent_wr.kind  <= lat_mon_pkg::KIND_SENT;
                o_sent_wr.idx   <= tx_idx;
                o_sent_wr.stamp <= timer;
            end

            // Pair with the oldest pending transmit
            if (rcv_ev) begin
                q_rd            <= q_rd + 1'b1;
                rx_ptr          <= rx_ptr + 1'b1;
                o_rcvd_wr.kind  <= lat_mon_pkg::KIND_RCVD;
                o_rcvd_wr.idx   <= rx_ptr[lat_mon_pkg::SAMPLE_AW-1:0];
                o_rcvd_wr.stamp <= timer;
                o_delta.sent    <= sent_q[q_rd];
                o_delta.rcvd    <= timer;
            end

            case ({send_ev, rcv_ev})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    assign o_status.rcvd_ptr = rx_ptr;
    assign o_status.pending  = pending;

endmodule

`default_nettype wire

// File: rtl/lat_mon_pkg.sv
`default_nettype none

package lat_mon_pkg;

    // Measurement geometry
    localparam int TIMER_W      = 16;
    localparam int SAMPLE_DEPTH = 256;
    localparam int SAMPLE_AW    = 8;
    localparam int RAM_AW       = SAMPLE_AW + 1;
    localparam int FULL_THRESH  = SAMPLE_DEPTH - 16;
    localparam int PENDING_MAX  = 15;
    localparam int PEND_W       = $clog2(PENDING_MAX + 1);
    localparam int DELTA_ADJ    = 5;

    // Record kind, also the low bit of a memory address
    localparam logic KIND_SENT = 1'b0;
    localparam logic KIND_RCVD = 1'b1;

    typedef logic [TIMER_W-1:0] timer_t;

    // Pair index with wrap bit
    typedef logic [SAMPLE_AW:0] ptr_t;

    typedef struct packed {
        logic                 valid;
        logic                 kind;
        logic [SAMPLE_AW-1:0] idx;
        timer_t               stamp;
    } rec_wr_t;

    typedef struct packed {
        logic   valid;
        timer_t sent;
        timer_t rcvd;
    } delta_t;

    typedef struct packed {
        logic [31:0] cnt;
        logic [31:0] sum;
        timer_t      lat_min;
        timer_t      lat_max;
    } stats_t;

    typedef struct packed {
        logic go;
        logic clear;
    } ctrl_t;

    typedef struct packed {
        ptr_t              rcvd_ptr;
        logic [PEND_W-1:0] pending;
    } cap_status_t;

endpackage

`default_nettype wire

// File: rtl/lat_mon_top.sv
`timescale 1ns/100ps
`default_nettype none

module lat_mon_top (
    input  logic                lat_clk,
    input  logic                lat_rstn,
    input  lat_wb_pkg::wb_req_t i_wb,
    output lat_wb_pkg::wb_rsp_t o_wb,
    input  logic                i_tx_sof,
    input  logic                i_rx_sof,
    output lat_mon_pkg::stats_t o_stats
);

    lat_mon_pkg::ctrl_t          ctrl;
    lat_mon_pkg::rec_wr_t        sent_wr;
    lat_mon_pkg::rec_wr_t        rcvd_wr;
    lat_mon_pkg::delta_t         delta;
    lat_mon_pkg::cap_status_t    cap_status;
    lat_wb_pkg::ram_rd_t         ram_rd_req;
    logic                        rd_active;
    logic                        rd_grant;
    logic                        rd_valid;
    lat_mon_pkg::timer_t         rd_data;
    logic                        ram_en;
    logic                        ram_we;
    logic [lat_mon_pkg::RAM_AW-1:0] ram_addr;
    lat_mon_pkg::timer_t         ram_wdata;
    lat_mon_pkg::timer_t         ram_rdata;

    // ############################################################
    // Measurement path
    // ############################################################
    lat_event_capture u_capture (
        .i_clk     (lat_clk),
        .i_rstn    (lat_rstn),
        .i_ctrl    (ctrl),
        .i_tx_sof  (i_tx_sof),
        .i_rx_sof  (i_rx_sof),
        .o_sent_wr (sent_wr),
        .o_rcvd_wr (rcvd_wr),
        .o_delta   (delta),
        .o_status  (cap_status)
    );

    lat_delta_stats u_stats (
        .i_clk   (lat_clk),
        .i_rstn  (lat_rstn),
        .i_ctrl  (ctrl),
        .i_delta (delta),
        .o_stats (o_stats)
    );

    // ############################################################
    // Shared sample memory and bus slave
    // ############################################################
    lat_sample_arbiter u_arbiter (
        .i_clk       (lat_clk),
        .i_rstn      (lat_rstn),
        .i_sent_wr   (sent_wr),
        .i_rcvd_wr   (rcvd_wr),
        .i_rd_req    (ram_rd_req),
        .i_rd_active (rd_active),
        .o_rd_grant  (rd_grant),
        .o_rd_valid  (rd_valid),
        .o_rd_data   (rd_data),
        .o_ram_en    (ram_en),
        .o_ram_we    (ram_we),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata)
    );

    lat_sample_ram u_ram (
        .i_clk   (lat_clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    lat_wb_regs u_regs (
        .i_clk       (lat_clk),
        .i_rstn      (lat_rstn),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .i_status    (cap_status),
        .o_ctrl      (ctrl),
        .o_rd_req    (ram_rd_req),
        .o_rd_active (rd_active),
        .i_rd_grant  (rd_grant),
        .i_rd_valid  (rd_valid),
        .i_rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/lat_sample_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module lat_sample_arbiter (
    input  logic                             i_clk,
    input  logic                             i_rstn,
    input  lat_mon_pkg::rec_wr_t             i_sent_wr,
    input  lat_mon_pkg::rec_wr_t             i_rcvd_wr,
    input  lat_wb_pkg::ram_rd_t              i_rd_req,
    input  logic                             i_rd_active,
    output logic                             o_rd_grant,
    output logic                             o_rd_valid,
    output lat_mon_pkg::timer_t              o_rd_data,
    output logic                             o_ram_en,
    output logic                             o_ram_we,
    output logic [lat_mon_pkg::RAM_AW-1:0]   o_ram_addr,
    output lat_mon_pkg::timer_t              o_ram_wdata,
    input  lat_mon_pkg::timer_t              i_ram_rdata
);

    lat_mon_pkg::rec_wr_t rcvd_hold;
    lat_mon_pkg::rec_wr_t rcvd_cur;
    logic                 gnt_sent;
    logic                 gnt_rcvd;
    logic                 gnt_rd;
    logic                 rd_valid_q;

    // Held receive record goes first, a new one cannot arrive behind it
    assign rcvd_cur = rcvd_hold.valid ? rcvd_hold : i_rcvd_wr;

    // ############################################################
    // Fixed priority: sent, received, bus read
    // ############################################################
    assign gnt_sent = i_sent_wr.valid;
    assign gnt_rcvd = rcvd_cur.valid & !gnt_sent;
    assign gnt_rd   = i_rd_req.valid & i_rd_active & !gnt_sent & !rcvd_cur.valid;

    // Sent writer always wins, so only the received writer is ever held
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            rcvd_hold.valid <= 1'b0;
        end else if (rcvd_cur.valid && !gnt_rcvd) begin
            rcvd_hold <= rcvd_cur;
        end else begin
            rcvd_hold.valid <= 1'b0;
        end
    end

    always_comb begin
        o_ram_addr  = {i_rd_req.idx, i_rd_req.kind};
        o_ram_wdata = rcvd_cur.stamp;
        if (gnt_sent) begin
            o_ram_addr  = {i_sent_wr.idx, i_sent_wr.kind};
            o_ram_wdata = i_sent_wr.stamp;
        end else if (gnt_rcvd) begin
            o_ram_addr  = {rcvd_cur.idx, rcvd_cur.kind};
        end
    end

    assign o_ram_en = gnt_sent | gnt_rcvd | gnt_rd;
    assign o_ram_we = gnt_sent | gnt_rcvd;

    // Read data is valid the cycle after its grant
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= gnt_rd;
        end
    end

    assign o_rd_grant = gnt_rd;
    assign o_rd_valid = rd_valid_q;
    assign o_rd_data  = i_ram_rdata;

endmodule

`default_nettype wire

// File: rtl/lat_sample_ram.sv
`timescale 1ns/100ps
`default_nettype none

module lat_sample_ram (
    input  logic                           i_clk,
    input  logic                           i_en,
    input  logic                           i_we,
    input  logic [lat_mon_pkg::RAM_AW-1:0] i_addr,
    input  lat_mon_pkg::timer_t            i_wdata,
    output lat_mon_pkg::timer_t            o_rdata
);

    // Address is {pair index, kind}
    lat_mon_pkg::timer_t mem [2**lat_mon_pkg::RAM_AW];

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lat_wb_pkg.sv
`default_nettype none

package lat_wb_pkg;

    localparam int WB_DW = 32;
    localparam int WB_AW = 4;

    // Register map
    localparam logic [WB_AW-1:0] REG_CTRL   = 4'd0;
    localparam logic [WB_AW-1:0] REG_STATUS = 4'd1;
    localparam logic [WB_AW-1:0] REG_SENT   = 4'd2;
    localparam logic [WB_AW-1:0] REG_RCVD   = 4'd3;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

    // Read data, status view or sample view of one word
    typedef struct packed {
        logic [WB_DW-lat_mon_pkg::PEND_W-lat_mon_pkg::SAMPLE_AW-3:0] pad;
        logic                                                         full;
        logic [lat_mon_pkg::PEND_W-1:0]                               pending;
        lat_mon_pkg::ptr_t                                            count;
    } status_word_t;

    typedef struct packed {
        logic [WB_DW-lat_mon_pkg::TIMER_W-1:0] pad;
        lat_mon_pkg::timer_t                   stamp;
    } sample_word_t;

    typedef union packed {
        status_word_t status;
        sample_word_t sample;
    } rd_word_u;

    typedef struct packed {
        logic                              valid;
        logic                              kind;
        logic [lat_mon_pkg::SAMPLE_AW-1:0] idx;
    } ram_rd_t;

endpackage

`default_nettype wire

// File: rtl/lat_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module lat_wb_regs (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    input  lat_wb_pkg::wb_req_t      i_wb,
    output lat_wb_pkg::wb_rsp_t      o_wb,
    input  lat_mon_pkg::cap_status_t i_status,
    output lat_mon_pkg::ctrl_t       o_ctrl,
    output lat_wb_pkg::ram_rd_t      o_rd_req,
    output logic                     o_rd_active,
    input  logic                     i_rd_grant,
    input  logic                     i_rd_valid,
    input  lat_mon_pkg::timer_t      i_rd_data
);

    lat_mon_pkg::ptr_t    rd_ptr;
    lat_mon_pkg::ptr_t    rec_cnt;
    lat_wb_pkg::ram_rd_t  rd_req_q;
    lat_wb_pkg::rd_word_u rd_word;
    logic                 go_q;
    logic                 clear_q;
    logic                 ack_q;
    logic                 rd_busy;
    logic                 full;
    logic                 bus_req;
    logic                 is_sample;

    // Records written but not yet read out
    assign rec_cnt = i_status.rcvd_ptr - rd_ptr;
    assign full    = (rec_cnt >= lat_mon_pkg::FULL_THRESH);

    // New access, not yet answered
    assign bus_req   = i_wb.cyc & i_wb.stb & !ack_q & !rd_busy;
    assign is_sample = !i_wb.we
                     & (i_wb.adr == lat_wb_pkg::REG_SENT || i_wb.adr == lat_wb_pkg::REG_RCVD);

    // ############################################################
    // Control register
    // ############################################################
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            go_q    <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            if (bus_req && i_wb.we && i_wb.adr == lat_wb_pkg::REG_CTRL) begin
                go_q    <= i_wb.dat[0];
                clear_q <= i_wb.dat[1];
            end else if (full) begin
                go_q <= 1'b0;
            end
        end
    end

    // ############################################################
    // Handshake and sample read-out
    // ############################################################
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            ack_q    <= 1'b0;
            rd_busy  <= 1'b0;
            rd_req_q <= '0;
            rd_ptr   <= '0;
        end else begin
            ack_q <= 1'b0;
            if (i_rd_grant) begin
                rd_req_q.valid <= 1'b0;
            end
            if (bus_req && is_sample) begin
                rd_busy        <= 1'b1;
                rd_req_q.valid <= 1'b1;
                rd_req_q.kind  <= (i_wb.adr == lat_wb_pkg::REG_RCVD);
                rd_req_q.idx   <= rd_ptr[lat_mon_pkg::SAMPLE_AW-1:0];
            end else if (bus_req) begin
                ack_q <= 1'b1;
            end
            if (rd_busy && i_rd_valid) begin
                ack_q   <= 1'b1;
                rd_busy <= 1'b0;
                // Received time closes the record
                if (rd_req_q.kind && rec_cnt != '0) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (clear_q) begin
                rd_ptr <= '0;
            end
            // Master gave up the cycle
            if (!i_wb.cyc) begin
                rd_busy        <= 1'b0;
                rd_req_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus_req && !i_wb.we) begin
            case (i_wb.adr)
                lat_wb_pkg::REG_CTRL: begin
                    rd_word <= lat_wb_pkg::WB_DW'(go_q);
                end
                lat_wb_pkg::REG_STATUS: begin
                    rd_word.status.pad     <= '0;
                    rd_word.status.full    <= full;
                    rd_word.status.pending <= i_status.pending;
                    rd_word.status.count   <= rec_cnt;
                end
                default: begin
                    rd_word <= '0;
                end
            endcase
        end else if (rd_busy && i_rd_valid) begin
            rd_word.sample.pad   <= '0;
            rd_word.sample.stamp <= i_rd_data;
        end
    end

    assign o_wb.ack     = ack_q;
    assign o_wb.dat     = rd_word;
    assign o_ctrl.go    = go_q;
    assign o_ctrl.clear = clear_q;
    assign o_rd_req     = rd_req_q;
    assign o_rd_active  = rd_busy & i_wb.cyc;

endmodule

`default_nettype wire

// File: tb/lat_mon_properties.sv
`timescale 1ns/100ps
`default_nettype none

module lat_mon_properties (
    input logic i_clk,
    input logic i_rstn,
    input logic i_rd_grant,
    input logic i_ack,
    input logic i_stb
);

    // Failed assertions so far
    int unsigned err_cnt = 0;

    // Memory port granted once per sample read
    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_rd_grant |=> !i_rd_grant)
        else begin
            err_cnt++;
            $error("Memory read granted in two cycles in a row");
        end

    a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_ack |=> !i_ack)
        else begin
            err_cnt++;
            $error("Bus ack held longer than one cycle");
        end

    a_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_ack |-> i_stb)
        else begin
            err_cnt++;
            $error("Bus ack without strobe");
        end

endmodule

bind lat_wb_regs lat_mon_properties u_bus_props (
    .i_clk      (i_clk),
    .i_rstn     (i_rstn),
    .i_rd_grant (i_rd_grant),
    .i_ack      (ack_q),
    .i_stb      (i_wb.stb)
);

`default_nettype wire

// File: tb/tb_lat_mon.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lat_mon;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int BUS_TIMEOUT = 50;

    logic                lat_clk;
    logic                lat_rstn;
    lat_wb_pkg::wb_req_t i_wb;
    lat_wb_pkg::wb_rsp_t o_wb;
    logic                i_tx_sof;
    logic                i_rx_sof;
    lat_mon_pkg::stats_t o_stats;

    // Reference model state
    int                   cycle_no = 0;
    int                   sent_cyc_q[$];
    int                   gap_q[$];
    int                   rec_cnt;
    lat_mon_pkg::stats_t  exp_stats;
    int                   tx_wait;
    int                   rx_wait;
    int                   fail_cnt;
    lat_wb_pkg::rd_word_u word;
    lat_wb_pkg::rd_word_u sent_w;
    lat_wb_pkg::rd_word_u rcvd_w;
    int                   n_rec;

    lat_mon_top u_dut (
        .lat_clk  (lat_clk),
        .lat_rstn (lat_rstn),
        .i_wb     (i_wb),
        .o_wb     (o_wb),
        .i_tx_sof (i_tx_sof),
        .i_rx_sof (i_rx_sof),
        .o_stats  (o_stats)
    );

    initial begin
        lat_clk = 1'b0;
        forever #(CLK_PERIOD / 2) lat_clk = ~lat_clk;
    end

    // Edge count as the time base of the model
    always @(posedge lat_clk) begin
        cycle_no <= cycle_no + 1;
    end

    // ############################################################
    // Reporting and compare tasks
    // ############################################################
    task automatic report_fail(input string what);
        fail_cnt++;
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic string stats_text(input lat_mon_pkg::stats_t s);
        return $sformatf("cnt %0d sum %0d min %h max %h", s.cnt, s.sum, s.lat_min, s.lat_max);
    endfunction

    function automatic string status_text(input lat_wb_pkg::rd_word_u w);
        return $sformatf("full %b pending %0d count %0d", w.status.full, w.status.pending,
                         w.status.count);
    endfunction

    task automatic compare_time(input string name, input lat_mon_pkg::timer_t exp_v,
                                input lat_mon_pkg::timer_t act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic verify_stats(input string name, input lat_mon_pkg::stats_t exp_v,
                                input lat_mon_pkg::stats_t act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("[ERROR] %s: expected %s, actual %s", name,
                                  stats_text(exp_v), stats_text(act_v)));
        end
    endtask

    task automatic check_status(input string name, input lat_wb_pkg::rd_word_u exp_v,
                                input lat_wb_pkg::rd_word_u act_v);
        if (act_v.status !== exp_v.status) begin
            report_fail($sformatf("[ERROR] %s: expected %s, actual %s", name,
                                  status_text(exp_v), status_text(act_v)));
        end
    endtask

    task automatic expect_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            report_fail($sformatf("[ERROR] %s: expected %b, actual %b", name, exp_v, act_v));
        end
    endtask

    // ############################################################
    // Reference model
    // ############################################################
    task automatic reset_model();
        sent_cyc_q.delete();
        gap_q.delete();
        rec_cnt           = 0;
        exp_stats.cnt     = '0;
        exp_stats.sum     = '0;
        exp_stats.lat_min = '1;
        exp_stats.lat_max = '0;
    endtask

    function automatic lat_wb_pkg::rd_word_u status_model();
        lat_wb_pkg::rd_word_u w;
        w                = '0;
        w.status.full    = (rec_cnt >= lat_mon_pkg::FULL_THRESH);
        w.status.pending = lat_mon_pkg::PEND_W'(sent_cyc_q.size());
        w.status.count   = lat_mon_pkg::ptr_t'(rec_cnt);
        return w;
    endfunction

    // One cycle of event inputs with the model following along
    task automatic drive_cycle(input logic tx, input logic rx, input logic go);
        int                  pend_before;
        int                  gap;
        lat_mon_pkg::timer_t lat;
        @(posedge lat_clk);
        #DRIVE_DLY;
        i_tx_sof    = tx;
        i_rx_sof    = rx;
        pend_before = sent_cyc_q.size();
        // A receive pairs with the oldest transmit still in flight
        if (rx && pend_before != 0) begin
            gap = cycle_no - sent_cyc_q.pop_front();
            gap_q.push_back(gap);
            rec_cnt++;
            lat           = lat_mon_pkg::timer_t'(gap - lat_mon_pkg::DELTA_ADJ);
            exp_stats.cnt = exp_stats.cnt + 1;
            exp_stats.sum = exp_stats.sum + 32'(lat);
            if (lat < exp_stats.lat_min) begin
                exp_stats.lat_min = lat;
            end
            if (lat > exp_stats.lat_max) begin
                exp_stats.lat_max = lat;
            end
        end
        if (tx && go && pend_before != lat_mon_pkg::PENDING_MAX) begin
            sent_cyc_q.push_back(cycle_no);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(1'b0, 1'b0, 1'b0);
    endtask

    // Random starts at least 4 cycles apart on each input
    task automatic run_traffic(input int cycles, input logic tx_on, input logic rx_on,
                               input logic go);
        logic tx;
        logic rx;
        for (int i = 0; i < cycles; i++) begin
            tx = tx_on && (tx_wait == 0);
            rx = rx_on && (rx_wait == 0);
            tx_wait = tx ? 3 + int'($urandom % 8) : (tx_wait > 0 ? tx_wait - 1 : 0);
            rx_wait = rx ? 3 + int'($urandom % 8) : (rx_wait > 0 ? rx_wait - 1 : 0);
            drive_cycle(tx, rx, go);
        end
        idle(8);
    endtask

    // ############################################################
    // Wishbone master
    // ############################################################
    task automatic bus_cycle(input logic we, input logic [lat_wb_pkg::WB_AW-1:0] adr,
                             input logic [31:0] wdat, output lat_wb_pkg::rd_word_u rdat);
        int waited;
        @(posedge lat_clk);
        #DRIVE_DLY;
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = we;
        i_wb.adr = adr;
        i_wb.dat = wdat;
        waited   = 0;
        do begin
            @(posedge lat_clk);
            #DRIVE_DLY;
            waited++;
        end while (!o_wb.ack && waited < BUS_TIMEOUT);
        if (!o_wb.ack) begin
            report_fail($sformatf("Bus access to register %0d was never acknowledged", adr));
        end
        rdat = o_wb.dat;
        // Request held through the ack cycle
        @(posedge lat_clk);
        #DRIVE_DLY;
        i_wb = '0;
    endtask

    task automatic compare_status_reg(input string name);
        lat_wb_pkg::rd_word_u w;
        bus_cycle(1'b0, lat_wb_pkg::REG_STATUS, 32'd0, w);
        check_status(name, status_model(), w);
    endtask

    // ############################################################
    // Test sequence
    // ############################################################
    initial begin
        void'($urandom(32'h16a9));
        lat_rstn = 1'b0;
        i_wb     = '0;
        i_tx_sof = 1'b0;
        i_rx_sof = 1'b0;
        tx_wait  = 0;
        rx_wait  = 0;
        fail_cnt = 0;
        reset_model();
        repeat (2) @(posedge lat_clk);
        #DRIVE_DLY;
        lat_rstn = 1'b1;
        verify_stats("stats after reset", exp_stats, o_stats);

        // Nothing recorded while go is clear
        run_traffic(200, 1'b1, 1'b1, 1'b0);
        compare_status_reg("status with go clear");
        verify_stats("stats with go clear", exp_stats, o_stats);

        // Pending limit and then a drain with extra receives
        bus_cycle(1'b1, lat_wb_pkg::REG_CTRL, 32'd1, word);
        run_traffic(200, 1'b1, 1'b0, 1'b1);
        compare_status_reg("status at pending limit");
        run_traffic(200, 1'b0, 1'b1, 1'b1);
        compare_status_reg("status after drain");

        // Random pairs and a read-back of every record
        run_traffic(800, 1'b1, 1'b1, 1'b1);
        run_traffic(200, 1'b0, 1'b1, 1'b1);
        compare_status_reg("status after random traffic");
        verify_stats("stats after random traffic", exp_stats, o_stats);
        n_rec = rec_cnt;
        for (int i = 0; i < n_rec; i++) begin
            bus_cycle(1'b0, lat_wb_pkg::REG_SENT, 32'd0, sent_w);
            bus_cycle(1'b0, lat_wb_pkg::REG_RCVD, 32'd0, rcvd_w);
            compare_time($sformatf("record %0d gap", i),
                         lat_mon_pkg::timer_t'(gap_q.pop_front()),
                         rcvd_w.sample.stamp - sent_w.sample.stamp);
            rec_cnt--;
        end
        compare_status_reg("status after read-out");

        // Clear with records stored and transmits still in flight
        run_traffic(40, 1'b1, 1'b1, 1'b1);
        run_traffic(40, 1'b1, 1'b0, 1'b1);
        compare_status_reg("status before clear");
        bus_cycle(1'b1, lat_wb_pkg::REG_CTRL, 32'd2, word);
        reset_model();
        idle(4);
        compare_status_reg("status after clear");
        verify_stats("stats after clear", exp_stats, o_stats);

        // Fill to the threshold
        bus_cycle(1'b1, lat_wb_pkg::REG_CTRL, 32'd1, word);
        for (int i = 0; i < lat_mon_pkg::FULL_THRESH; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b1);
            drive_cycle(1'b0, 1'b0, 1'b1);
            drive_cycle(1'b0, 1'b1, 1'b1);
            repeat (3) drive_cycle(1'b0, 1'b0, 1'b1);
        end
        idle(6);
        bus_cycle(1'b0, lat_wb_pkg::REG_CTRL, 32'd0, word);
        expect_flag("go after full", 1'b0, word[0]);
        run_traffic(120, 1'b1, 1'b1, 1'b0);
        compare_status_reg("status when full");
        verify_stats("stats when full", exp_stats, o_stats);

        if (fail_cnt == 0 && u_dut.u_regs.u_bus_props.err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
